//--- decode_stage.f
+incdir+verilog
verilog/decode_pkg.sv
verilog/decode_ctrl.sv
verilog/op_decoder.sv
verilog/imm_gen.sv
verilog/operand_bypass.sv
verilog/stage_reg.sv
verilog/decode_stage.sv
test/tb_decode_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the decode stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_decode_stage \
    -f decode_stage.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_decode_stage 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

//--- test/tb_decode_stage.sv
`default_nettype none
`timescale 1ns/1ps

`include "decode_consts.svh"

module tb_decode_stage
    import decode_pkg::*;
();

    localparam int MAX_CYCLES = 400;

    localparam alu_op_e R_OPS [10] = '{ADD, SUB, SLT, SLTU, XOR, OR, AND, SLL, SRL, SRA};
    localparam logic [2:0] R_F3 [10] = '{`FUNCT3_ADD, `FUNCT3_ADD, `FUNCT3_SLT, `FUNCT3_SLTU,
        `FUNCT3_XOR, `FUNCT3_OR, `FUNCT3_AND, `FUNCT3_SLL, `FUNCT3_SR, `FUNCT3_SR};
    localparam alu_op_e B_OPS [6] = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
    localparam logic [2:0] B_F3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    localparam alu_op_e L_OPS [5] = '{LB, LH, LW, LBU, LHU};
    localparam logic [2:0] L_F3 [5] = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
    localparam alu_op_e S_OPS [3] = '{SB, SH, SW};
    localparam logic [2:0] S_F3 [3] = '{3'b000, 3'b001, 3'b010};

    logic      clk;
    logic      rst_n_i;
    logic      ifu_vld_i;
    word_t     ifu_ins_i;
    word_t     ifu_pc_i;
    logic      ifu_rdy_o;
    reg_addr_t rf_src1_addr_o;
    reg_addr_t rf_src2_addr_o;
    word_t     rf_src1_data_i;
    word_t     rf_src2_data_i;
    logic      alu_wb_vld_i;
    logic      alu_wb_ld_i;
    reg_addr_t alu_wb_addr_i;
    word_t     alu_wb_data_i;
    logic      lsu_wb_vld_i;
    logic      lsu_wb_ld_i;
    reg_addr_t lsu_wb_addr_i;
    word_t     lsu_wb_data_i;
    logic      rf_wb_vld_i;
    reg_addr_t rf_wb_addr_i;
    word_t     rf_wb_data_i;
    logic      alu_rdy_i;
    logic      alu_flush_i;
    logic      alu_vld_o;
    alu_op_e   alu_op_o;
    logic      alu_wb_vld_o;
    reg_addr_t alu_wb_addr_o;
    word_t     alu_src1_o;
    word_t     alu_src2_o;
    word_t     alu_br_st_imm_o;
    word_t     alu_pc_o;

    int          errors;
    int          cycles;
    string       test_name;
    reg_addr_t   cur_rs1;
    reg_addr_t   cur_rs2;
    reg_addr_t   cur_rd;
    word_t       cur_d1;
    word_t       cur_d2;
    word_t       cur_pc;

    decode_stage UUT (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .ifu_vld_i       (ifu_vld_i),
        .ifu_ins_i       (ifu_ins_i),
        .ifu_pc_i        (ifu_pc_i),
        .ifu_rdy_o       (ifu_rdy_o),
        .rf_src1_addr_o  (rf_src1_addr_o),
        .rf_src2_addr_o  (rf_src2_addr_o),
        .rf_src1_data_i  (rf_src1_data_i),
        .rf_src2_data_i  (rf_src2_data_i),
        .alu_wb_vld_i    (alu_wb_vld_i),
        .alu_wb_ld_i     (alu_wb_ld_i),
        .alu_wb_addr_i   (alu_wb_addr_i),
        .alu_wb_data_i   (alu_wb_data_i),
        .lsu_wb_vld_i    (lsu_wb_vld_i),
        .lsu_wb_ld_i     (lsu_wb_ld_i),
        .lsu_wb_addr_i   (lsu_wb_addr_i),
        .lsu_wb_data_i   (lsu_wb_data_i),
        .rf_wb_vld_i     (rf_wb_vld_i),
        .rf_wb_addr_i    (rf_wb_addr_i),
        .rf_wb_data_i    (rf_wb_data_i),
        .alu_rdy_i       (alu_rdy_i),
        .alu_flush_i     (alu_flush_i),
        .alu_vld_o       (alu_vld_o),
        .alu_op_o        (alu_op_o),
        .alu_wb_vld_o    (alu_wb_vld_o),
        .alu_wb_addr_o   (alu_wb_addr_o),
        .alu_src1_o      (alu_src1_o),
        .alu_src2_o      (alu_src2_o),
        .alu_br_st_imm_o (alu_br_st_imm_o),
        .alu_pc_o        (alu_pc_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles, %0d errors so far", cycles, errors);
            $display("Testbench failed");
            $finish;
        end
    end

    // instruction encoders, field layout from the rv32i spec
    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `STORE};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `BRANCH};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `JAL};
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic reg_addr_t rand_reg();
        return 5'(32'd1 + ($urandom % 32'd31));
    endfunction

    // lowest priority first, newer producers overwrite
    function automatic word_t fwd_model(input reg_addr_t rs, input word_t rf_data);
        word_t res;
        res = rf_data;
        if (rf_wb_vld_i && rf_wb_addr_i == rs) res = rf_wb_data_i;
        if (lsu_wb_vld_i && lsu_wb_addr_i == rs) res = lsu_wb_data_i;
        if (alu_wb_vld_i && alu_wb_addr_i == rs) res = alu_wb_data_i;
        return res;
    endfunction

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            errors++;
            $display("Error %s: %s expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_op(input string what, input alu_op_e exp, input alu_op_e act);
        if (act !== exp) begin
            errors++;
            $display("Error %s: %s expected %s, actual %s", test_name, what, exp.name(),
                     act.name());
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("Error %s: %s expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_out(input alu_op_e op, input logic wb, input reg_addr_t rd,
                             input word_t s1, input word_t s2, input word_t bsi);
        check_bit("alu_vld", 1'b1, alu_vld_o);
        check_op("alu_op", op, alu_op_o);
        check_bit("alu_wb_vld", wb, alu_wb_vld_o);
        check_word("alu_wb_addr", 32'(rd), 32'(alu_wb_addr_o));
        check_word("alu_src1", s1, alu_src1_o);
        check_word("alu_src2", s2, alu_src2_o);
        check_word("alu_br_st_imm", bsi, alu_br_st_imm_o);
        check_word("alu_pc", cur_pc, alu_pc_o);
    endtask

    task automatic pick_data();
        cur_rs1 = rand_reg();
        cur_rs2 = rand_reg();
        cur_rd = rand_reg();
        cur_d1 = $urandom;
        cur_d2 = $urandom;
        cur_pc = $urandom & 32'hffff_fffc;
    endtask

    task automatic start_ins(input word_t ins);
        @(posedge clk);
        ifu_vld_i <= 1'b1;
        ifu_ins_i <= ins;
        ifu_pc_i <= cur_pc;
        rf_src1_data_i <= cur_d1;
        rf_src2_data_i <= cur_d2;
    endtask

    // returns on the falling edge after the capture edge
    task automatic wait_accept();
        @(negedge clk);
        while (!(ifu_rdy_o && !alu_flush_i)) @(negedge clk);
        @(posedge clk);
        ifu_vld_i <= 1'b0;
        @(negedge clk);
    endtask

    task automatic run_ins(input word_t ins);
        start_ins(ins);
        wait_accept();
    endtask

    task automatic drive_fwd(input logic av, input reg_addr_t aa, input logic lv,
                             input reg_addr_t la, input logic wv, input reg_addr_t wa);
        @(posedge clk);
        alu_wb_vld_i <= av;
        alu_wb_ld_i <= 1'b0;
        alu_wb_addr_i <= aa;
        alu_wb_data_i <= $urandom;
        lsu_wb_vld_i <= lv;
        lsu_wb_ld_i <= 1'b0;
        lsu_wb_addr_i <= la;
        lsu_wb_data_i <= $urandom;
        rf_wb_vld_i <= wv;
        rf_wb_addr_i <= wa;
        rf_wb_data_i <= $urandom;
    endtask

    task automatic test_alu_decode();
        logic [6:0]  f7;
        logic [11:0] imm;
        test_name = "alu_decode";
        for (int i = 0; i < 10; i++) begin
            f7 = (R_OPS[i] == SUB || R_OPS[i] == SRA) ? `FUNCT7_ALT : `FUNCT7_NORM;
            pick_data();
            run_ins(enc_r(f7, cur_rs2, cur_rs1, R_F3[i], cur_rd, `OP));
            check_out(R_OPS[i], 1'b1, cur_rd, cur_d1, cur_d2, '0);
            check_word("rf_src1_addr", 32'(cur_rs1), 32'(rf_src1_addr_o));
            check_word("rf_src2_addr", 32'(cur_rs2), 32'(rf_src2_addr_o));
            if (R_OPS[i] != SUB) begin
                pick_data();
                imm = 12'($urandom);
                // shift amounts keep funct7 in the upper immediate bits
                if (R_OPS[i] inside {SLL, SRL, SRA}) imm[11:5] = f7;
                run_ins(enc_i(imm, cur_rs1, R_F3[i], cur_rd, `OP_IMM));
                check_out(R_OPS[i], 1'b1, cur_rd, cur_d1, sext12(imm), '0);
            end
        end
    endtask

    task automatic test_imm_ctrl_flow();
        logic [11:0] imm;
        logic [12:0] bimm;
        logic [19:0] uimm;
        logic [20:0] jimm;
        test_name = "imm_ctrl_flow";
        for (int i = 0; i < 6; i++) begin
            pick_data();
            bimm = 13'($urandom);
            bimm[0] = 1'b0;
            run_ins(enc_b(bimm, cur_rs2, cur_rs1, B_F3[i]));
            check_out(B_OPS[i], 1'b0, {bimm[4:1], bimm[11]}, cur_d1, cur_d2,
                      {{19{bimm[12]}}, bimm});
        end
        for (int i = 0; i < 5; i++) begin
            pick_data();
            imm = 12'($urandom);
            run_ins(enc_i(imm, cur_rs1, L_F3[i], cur_rd, `LOAD));
            check_out(L_OPS[i], 1'b1, cur_rd, cur_d1, sext12(imm), '0);
        end
        for (int i = 0; i < 3; i++) begin
            pick_data();
            imm = 12'($urandom);
            run_ins(enc_s(imm, cur_rs2, cur_rs1, S_F3[i]));
            check_out(S_OPS[i], 1'b0, imm[4:0], cur_d1, cur_d2, sext12(imm));
        end
        pick_data();
        uimm = 20'($urandom);
        run_ins({uimm, cur_rd, `LUI});
        check_out(LUI, 1'b1, cur_rd, cur_d1, {uimm, 12'h000}, '0);
        pick_data();
        uimm = 20'($urandom);
        run_ins({uimm, cur_rd, `AUIPC});
        check_out(AUIPC, 1'b1, cur_rd, cur_d1, {uimm, 12'h000}, '0);
        pick_data();
        jimm = 21'($urandom);
        jimm[0] = 1'b0;
        run_ins(enc_j(jimm, cur_rd));
        check_out(JAL, 1'b1, cur_rd, cur_d1, {{11{jimm[20]}}, jimm}, '0);
        pick_data();
        imm = 12'($urandom);
        run_ins(enc_i(imm, cur_rs1, 3'b000, cur_rd, `JALR));
        check_out(JALR, 1'b1, cur_rd, cur_d1, sext12(imm), '0);
    endtask

    task automatic fwd_case(input logic av, input reg_addr_t aa, input logic lv,
                            input reg_addr_t la, input logic wv, input reg_addr_t wa,
                            input reg_addr_t rs1, input reg_addr_t rs2);
        drive_fwd(av, aa, lv, la, wv, wa);
        pick_data();
        run_ins(enc_r(`FUNCT7_NORM, rs2, rs1, `FUNCT3_ADD, cur_rd, `OP));
        check_out(ADD, 1'b1, cur_rd, fwd_model(rs1, cur_d1), fwd_model(rs2, cur_d2), '0);
    endtask

    task automatic test_forwarding();
        reg_addr_t   r1;
        reg_addr_t   r2;
        reg_addr_t   r3;
        logic [11:0] imm;
        test_name = "forwarding";
        r1 = rand_reg();
        r2 = 5'(r1 % 31 + 1);
        r3 = 5'(r2 % 31 + 1);
        fwd_case(1'b1, r1, 1'b1, r1, 1'b1, r2, r1, r2);
        fwd_case(1'b0, r1, 1'b1, r2, 1'b1, r2, r1, r2);
        fwd_case(1'b1, r2, 1'b1, r1, 1'b0, r1, r1, r2);
        fwd_case(1'b1, r3, 1'b0, r1, 1'b1, r1, r1, r2);
        fwd_case(1'b1, r1, 1'b1, r2, 1'b1, r3, r1, r2);
        // rs2 field of an i-type holds immediate bits and a load on it must not stall
        drive_fwd(1'b1, r2, 1'b1, r2, 1'b1, r2);
        alu_wb_ld_i <= 1'b1;
        lsu_wb_ld_i <= 1'b1;
        pick_data();
        imm = {7'($urandom), r2};
        start_ins(enc_i(imm, r1, `FUNCT3_ADD, cur_rd, `OP_IMM));
        @(negedge clk);
        check_bit("ifu_rdy on unused rs2", 1'b1, ifu_rdy_o);
        @(posedge clk);
        ifu_vld_i <= 1'b0;
        @(negedge clk);
        check_out(ADD, 1'b1, cur_rd, cur_d1, sext12(imm), '0);
        drive_fwd(1'b0, '0, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic stall_case(input logic from_lsu);
        word_t fwd;
        pick_data();
        cur_rs2 = 5'(cur_rs1 % 31 + 1);
        fwd = $urandom;
        @(posedge clk);
        alu_wb_vld_i <= !from_lsu;
        alu_wb_ld_i <= !from_lsu;
        alu_wb_addr_i <= cur_rs1;
        alu_wb_data_i <= fwd;
        lsu_wb_vld_i <= from_lsu;
        lsu_wb_ld_i <= from_lsu;
        lsu_wb_addr_i <= cur_rs2;
        lsu_wb_data_i <= fwd;
        start_ins(enc_r(`FUNCT7_NORM, cur_rs2, cur_rs1, `FUNCT3_ADD, cur_rd, `OP));
        repeat (3) begin
            @(negedge clk);
            check_bit("ifu_rdy in stall", 1'b0, ifu_rdy_o);
            check_bit("alu_vld in stall", 1'b0, alu_vld_o);
            @(posedge clk);
        end
        alu_wb_ld_i <= 1'b0;
        lsu_wb_ld_i <= 1'b0;
        wait_accept();
        check_out(ADD, 1'b1, cur_rd, from_lsu ? cur_d1 : fwd, from_lsu ? fwd : cur_d2, '0);
        @(posedge clk);
        alu_wb_vld_i <= 1'b0;
        lsu_wb_vld_i <= 1'b0;
    endtask

    task automatic test_load_stall();
        test_name = "load_stall";
        stall_case(1'b0);
        stall_case(1'b1);
    endtask

    task automatic test_backpressure_flush();
        test_name = "backpressure_flush";
        pick_data();
        @(posedge clk);
        alu_rdy_i <= 1'b0;
        run_ins(enc_r(`FUNCT7_NORM, cur_rs2, cur_rs1, `FUNCT3_XOR, cur_rd, `OP));
        check_out(XOR, 1'b1, cur_rd, cur_d1, cur_d2, '0);
        @(posedge clk);
        ifu_vld_i <= 1'b1;
        ifu_ins_i <= enc_r(`FUNCT7_ALT, cur_rs1, cur_rs2, `FUNCT3_ADD, cur_rd, `OP);
        ifu_pc_i <= cur_pc + 32'd4;
        repeat (3) begin
            @(negedge clk);
            check_bit("ifu_rdy held", 1'b0, ifu_rdy_o);
            check_out(XOR, 1'b1, cur_rd, cur_d1, cur_d2, '0);
            @(posedge clk);
        end
        alu_flush_i <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_bit("alu_vld after flush", 1'b0, alu_vld_o);
        @(posedge clk);
        @(negedge clk);
        check_bit("alu_vld during flush", 1'b0, alu_vld_o);
        check_word("alu_pc during flush", cur_pc, alu_pc_o);
        @(posedge clk);
        alu_flush_i <= 1'b0;
        ifu_vld_i <= 1'b0;
        alu_rdy_i <= 1'b1;
    endtask

    initial begin
        clk = 1'b0;
        rst_n_i = 1'b0;
        ifu_vld_i = 1'b0;
        ifu_ins_i = '0;
        ifu_pc_i = '0;
        rf_src1_data_i = '0;
        rf_src2_data_i = '0;
        alu_wb_vld_i = 1'b0;
        alu_wb_ld_i = 1'b0;
        alu_wb_addr_i = '0;
        alu_wb_data_i = '0;
        lsu_wb_vld_i = 1'b0;
        lsu_wb_ld_i = 1'b0;
        lsu_wb_addr_i = '0;
        lsu_wb_data_i = '0;
        rf_wb_vld_i = 1'b0;
        rf_wb_addr_i = '0;
        rf_wb_data_i = '0;
        alu_rdy_i = 1'b1;
        alu_flush_i = 1'b0;
        errors = 0;
        cycles = 0;
        void'($urandom(57));
        test_name = "reset";
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_bit("alu_vld in reset", 1'b0, alu_vld_o);
        check_bit("alu_wb_vld in reset", 1'b0, alu_wb_vld_o);
        check_word("alu_src1 in reset", '0, alu_src1_o);
        check_word("alu_pc in reset", '0, alu_pc_o);
        @(posedge clk);
        rst_n_i <= 1'b1;
        test_alu_decode();
        test_imm_ctrl_flow();
        test_forwarding();
        test_load_stall();
        test_backpressure_flush();
        repeat (2) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`default_nettype none
`timescale 1ns/1ps

`include "decode_consts.svh"

module decode_stage
    import decode_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      ifu_vld_i,
    input  word_t     ifu_ins_i,
    input  word_t     ifu_pc_i,
    output logic      ifu_rdy_o,
    output reg_addr_t rf_src1_addr_o,
    output reg_addr_t rf_src2_addr_o,
    input  word_t     rf_src1_data_i,
    input  word_t     rf_src2_data_i,
    input  logic      alu_wb_vld_i,
    input  logic      alu_wb_ld_i,
    input  reg_addr_t alu_wb_addr_i,
    input  word_t     alu_wb_data_i,
    input  logic      lsu_wb_vld_i,
    input  logic      lsu_wb_ld_i,
    input  reg_addr_t lsu_wb_addr_i,
    input  word_t     lsu_wb_data_i,
    input  logic      rf_wb_vld_i,
    input  reg_addr_t rf_wb_addr_i,
    input  word_t     rf_wb_data_i,
    input  logic      alu_rdy_i,
    input  logic      alu_flush_i,
    output logic      alu_vld_o,
    output alu_op_e   alu_op_o,
    output logic      alu_wb_vld_o,
    output reg_addr_t alu_wb_addr_o,
    output word_t     alu_src1_o,
    output word_t     alu_src2_o,
    output word_t     alu_br_st_imm_o,
    output word_t     alu_pc_o
);

    logic        capture;
    logic        ld_stall;
    alu_op_e     dec_op;
    ins_fmt_e    dec_fmt;
    logic        dec_wb_vld;
    word_t       imm;
    word_t       br_st_imm;
    dec_bundle_t bundle_d;
    dec_bundle_t bundle_q;
    src_pair_t   src_d;
    src_pair_t   src_q;

    decode_ctrl u_ctrl (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ifu_vld_i   (ifu_vld_i),
        .alu_rdy_i   (alu_rdy_i),
        .alu_flush_i (alu_flush_i),
        .ld_stall_i  (ld_stall),
        .ifu_rdy_o   (ifu_rdy_o),
        .capture_o   (capture),
        .alu_vld_o   (alu_vld_o)
    );

    op_decoder u_op_dec (
        .ins_i    (ifu_ins_i),
        .op_o     (dec_op),
        .fmt_o    (dec_fmt),
        .wb_vld_o (dec_wb_vld)
    );

    imm_gen u_imm_gen (
        .ins_i       (ifu_ins_i),
        .fmt_i       (dec_fmt),
        .imm_o       (imm),
        .br_st_imm_o (br_st_imm)
    );

    operand_bypass u_bypass (
        .ins_i          (ifu_ins_i),
        .fmt_i          (dec_fmt),
        .imm_i          (imm),
        .alu_wb_vld_i   (alu_wb_vld_i),
        .alu_wb_ld_i    (alu_wb_ld_i),
        .alu_wb_addr_i  (alu_wb_addr_i),
        .alu_wb_data_i  (alu_wb_data_i),
        .lsu_wb_vld_i   (lsu_wb_vld_i),
        .lsu_wb_ld_i    (lsu_wb_ld_i),
        .lsu_wb_addr_i  (lsu_wb_addr_i),
        .lsu_wb_data_i  (lsu_wb_data_i),
        .rf_wb_vld_i    (rf_wb_vld_i),
        .rf_wb_addr_i   (rf_wb_addr_i),
        .rf_wb_data_i   (rf_wb_data_i),
        .rf_src1_data_i (rf_src1_data_i),
        .rf_src2_data_i (rf_src2_data_i),
        .rf_src1_addr_o (rf_src1_addr_o),
        .rf_src2_addr_o (rf_src2_addr_o),
        .src_o          (src_d),
        .ld_stall_o     (ld_stall)
    );

    assign bundle_d.op        = dec_op;
    assign bundle_d.wb_vld    = dec_wb_vld;
    assign bundle_d.wb_addr   = ifu_ins_i[`RD_RNG];
    assign bundle_d.br_st_imm = br_st_imm;

    stage_reg #(.payload_t(dec_bundle_t)) u_bundle_reg (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .en_i    (capture),
        .d_i     (bundle_d),
        .q_o     (bundle_q)
    );

    stage_reg #(.payload_t(src_pair_t)) u_src_reg (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .en_i    (capture),
        .d_i     (src_d),
        .q_o     (src_q)
    );

    stage_reg #(.payload_t(word_t)) u_pc_reg (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .en_i    (capture),
        .d_i     (ifu_pc_i),
        .q_o     (alu_pc_o)
    );

    assign alu_op_o        = bundle_q.op;
    assign alu_wb_vld_o    = bundle_q.wb_vld;
    assign alu_wb_addr_o   = bundle_q.wb_addr;
    assign alu_br_st_imm_o = bundle_q.br_st_imm;
    assign alu_src1_o      = src_q.src1;
    assign alu_src2_o      = src_q.src2;

endmodule

`default_nettype wire

//--- verilog/stage_reg.sv
`default_nettype none
`timescale 1ns/1ps

`include "decode_consts.svh"

module stage_reg #(
    parameter type payload_t = logic [`XLEN-1:0]
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     en_i,
    input  payload_t d_i,
    output payload_t q_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q_o <= '0;
        end else if (en_i) begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

//--- verilog/operand_bypass.sv
`default_nettype none
`timescale 1ns/1ps

`include "decode_consts.svh"

module operand_bypass
    import decode_pkg::*;
(
    input  word_t     ins_i,
    input  ins_fmt_e  fmt_i,
    input  word_t     imm_i,
    input  logic      alu_wb_vld_i,
    input  logic      alu_wb_ld_i,
    input  reg_addr_t alu_wb_addr_i,
    input  word_t     alu_wb_data_i,
    input  logic      lsu_wb_vld_i,
    input  logic      lsu_wb_ld_i,
    input  reg_addr_t lsu_wb_addr_i,
    input  word_t     lsu_wb_data_i,
    input  logic      rf_wb_vld_i,
    input  reg_addr_t rf_wb_addr_i,
    input  word_t     rf_wb_data_i,
    input  word_t     rf_src1_data_i,
    input  word_t     rf_src2_data_i,
    output reg_addr_t rf_src1_addr_o,
    output reg_addr_t rf_src2_addr_o,
    output src_pair_t src_o,
    output logic      ld_stall_o
);

    logic use_rs1;
    logic use_rs2;

    assign rf_src1_addr_o = ins_i[`RS1_RNG];
    assign rf_src2_addr_o = ins_i[`RS2_RNG];

    // a pending load result cannot be forwarded yet
    function automatic logic ld_hit(input reg_addr_t rs);
        ld_hit = (alu_wb_vld_i && alu_wb_ld_i && alu_wb_addr_i == rs)
              || (lsu_wb_vld_i && lsu_wb_ld_i && lsu_wb_addr_i == rs);
    endfunction

    // newest result first: alu, lsu, rf write port, then rf read
    function automatic word_t fwd_data(input reg_addr_t rs, input word_t rf_data);
        if (alu_wb_vld_i && !alu_wb_ld_i && alu_wb_addr_i == rs) begin
            fwd_data = alu_wb_data_i;
        end else if (lsu_wb_vld_i && !lsu_wb_ld_i && lsu_wb_addr_i == rs) begin
            fwd_data = lsu_wb_data_i;
        end else if (rf_wb_vld_i && rf_wb_addr_i == rs) begin
            fwd_data = rf_wb_data_i;
        end else begin
            fwd_data = rf_data;
        end
    endfunction

    always_comb begin
        use_rs1 = (fmt_i != FMT_U) && (fmt_i != FMT_J);
        use_rs2 = (fmt_i inside {FMT_R, FMT_S, FMT_B});
        src_o.src1 = use_rs1 ? fwd_data(rf_src1_addr_o, rf_src1_data_i) : rf_src1_data_i;
        if (fmt_i inside {FMT_I, FMT_U, FMT_J}) begin
            src_o.src2 = imm_i;
        end else begin
            src_o.src2 = use_rs2 ? fwd_data(rf_src2_addr_o, rf_src2_data_i) : rf_src2_data_i;
        end
        ld_stall_o = (use_rs1 && ld_hit(rf_src1_addr_o)) || (use_rs2 && ld_hit(rf_src2_addr_o));
        assert (!ld_stall_o || alu_wb_vld_i || lsu_wb_vld_i)
            else $error("load stall without a valid producer");
    end

endmodule

`default_nettype wire

//--- verilog/imm_gen.sv
`default_nettype none
`timescale 1ns/1ps

`include "decode_consts.svh"

module imm_gen
    import decode_pkg::*;
(
    input  word_t    ins_i,
    input  ins_fmt_e fmt_i,
    output word_t    imm_o,
    output word_t    br_st_imm_o
);

    logic  sign;
    word_t i_imm;
    word_t s_imm;
    word_t b_imm;
    word_t u_imm;
    word_t j_imm;

    assign sign = ins_i[`IMM_SIGN_BIT];

    assign i_imm = {{(`XLEN-12){sign}}, ins_i[`I_IMM_RNG]};
    assign s_imm = {{(`XLEN-12){sign}}, ins_i[`S_IMM_HI_RNG], ins_i[`S_IMM_LO_RNG]};
    // bit 0 of branch and jump offsets is implied zero
    assign b_imm = {{(`XLEN-12){sign}}, ins_i[`B_IMM_11_BIT], ins_i[`B_IMM_10_5_RNG],
                    ins_i[`B_IMM_4_1_RNG], 1'b0};
    assign u_imm = {ins_i[`U_IMM_RNG], 12'b0};
    assign j_imm = {{(`XLEN-20){sign}}, ins_i[`J_IMM_19_12_RNG], ins_i[`J_IMM_11_BIT],
                    ins_i[`J_IMM_10_1_RNG], 1'b0};

    always_comb begin
        case (fmt_i)
            FMT_I:   imm_o = i_imm;
            FMT_S:   imm_o = s_imm;
            FMT_B:   imm_o = b_imm;
            FMT_U:   imm_o = u_imm;
            FMT_J:   imm_o = j_imm;
            default: imm_o = '0;
        endcase
    end

    assign br_st_imm_o = (fmt_i == FMT_B) ? b_imm : ((fmt_i == FMT_S) ? s_imm : '0);

endmodule

`default_nettype wire

//--- verilog/op_decoder.sv
`default_nettype none
`timescale 1ns/1ps

`include "decode_consts.svh"

module op_decoder
    import decode_pkg::*;
(
    input  word_t    ins_i,
    output alu_op_e  op_o,
    output ins_fmt_e fmt_o,
    output logic     wb_vld_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = ins_i[`OP_RNG];
    assign funct3 = ins_i[`FUNCT3_RNG];
    assign funct7 = ins_i[`FUNCT7_RNG];

    // funct7 only qualifies r-type ops, except shifts which check it for both
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic [6:0] f7,
                                         input logic is_reg);
        logic norm;
        logic alt;
        norm = (f7 == `FUNCT7_NORM);
        alt = (f7 == `FUNCT7_ALT);
        arith_op = OP_NONE;
        case (f3)
            `FUNCT3_ADD:  arith_op = (!is_reg || norm) ? ADD : (alt ? SUB : OP_NONE);
            `FUNCT3_SLT:  arith_op = (!is_reg || norm) ? SLT : OP_NONE;
            `FUNCT3_SLTU: arith_op = (!is_reg || norm) ? SLTU : OP_NONE;
            `FUNCT3_XOR:  arith_op = (!is_reg || norm) ? XOR : OP_NONE;
            `FUNCT3_OR:   arith_op = (!is_reg || norm) ? OR : OP_NONE;
            `FUNCT3_AND:  arith_op = (!is_reg || norm) ? AND : OP_NONE;
            `FUNCT3_SLL:  arith_op = norm ? SLL : OP_NONE;
            default:      arith_op = norm ? SRL : (alt ? SRA : OP_NONE);
        endcase
    endfunction

    always_comb begin
        op_o = OP_NONE;
        fmt_o = FMT_NONE;
        case (opcode)
            `OP: begin
                fmt_o = FMT_R;
                op_o = arith_op(funct3, funct7, 1'b1);
            end
            `OP_IMM: begin
                fmt_o = FMT_I;
                op_o = arith_op(funct3, funct7, 1'b0);
            end
            `LOAD: begin
                fmt_o = FMT_I;
                case (funct3)
                    `FUNCT3_ADD: op_o = LB;
                    `FUNCT3_SLL: op_o = LH;
                    `FUNCT3_SLT: op_o = LW;
                    `FUNCT3_XOR: op_o = LBU;
                    `FUNCT3_SR:  op_o = LHU;
                    default:     op_o = OP_NONE;
                endcase
            end
            `STORE: begin
                fmt_o = FMT_S;
                case (funct3)
                    `FUNCT3_ADD: op_o = SB;
                    `FUNCT3_SLL: op_o = SH;
                    `FUNCT3_SLT: op_o = SW;
                    default:     op_o = OP_NONE;
                endcase
            end
            `BRANCH: begin
                fmt_o = FMT_B;
                case (funct3)
                    `FUNCT3_ADD: op_o = BEQ;
                    `FUNCT3_SLL: op_o = BNE;
                    `FUNCT3_XOR: op_o = BLT;
                    `FUNCT3_SR:  op_o = BGE;
                    `FUNCT3_OR:  op_o = BLTU;
                    `FUNCT3_AND: op_o = BGEU;
                    default:     op_o = OP_NONE;
                endcase
            end
            `LUI: begin
                fmt_o = FMT_U;
                op_o = LUI;
            end
            `AUIPC: begin
                fmt_o = FMT_U;
                op_o = AUIPC;
            end
            `JAL: begin
                fmt_o = FMT_J;
                op_o = JAL;
            end
            `JALR: begin
                fmt_o = FMT_I;
                op_o = JALR;
            end
            default: begin
                fmt_o = FMT_NONE;
                op_o = OP_NONE;
            end
        endcase
        wb_vld_o = (fmt_o inside {FMT_R, FMT_I, FMT_U, FMT_J});
        assert (fmt_o != FMT_NONE || op_o == OP_NONE)
            else $error("op decoded for unknown format");
    end

endmodule

`default_nettype wire

//--- verilog/decode_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

`include "decode_consts.svh"

module decode_ctrl (
    input  logic clk,
    input  logic rst_n_i,
    input  logic ifu_vld_i,
    input  logic alu_rdy_i,
    input  logic alu_flush_i,
    input  logic ld_stall_i,
    output logic ifu_rdy_o,
    output logic capture_o,
    output logic alu_vld_o
);

    // free slot when the alu drains or nothing is held
    assign ifu_rdy_o = (alu_rdy_i | ~alu_vld_o) & ~ld_stall_i;

    assign capture_o = ifu_vld_i & ifu_rdy_o & ~alu_flush_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            alu_vld_o <= 1'b0;
        end else begin
            alu_vld_o <= capture_o | (alu_vld_o & ~alu_rdy_i & ~alu_flush_i);
        end
    end

    a_no_rdy_in_stall: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        ld_stall_i |-> !ifu_rdy_o
    ) else $error("fetch ready raised during load-use stall");

    // held instruction must survive back-pressure
    a_hold_vld: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (alu_vld_o && !alu_rdy_i && !alu_flush_i) |=> alu_vld_o
    ) else $error("alu valid dropped under back-pressure");

endmodule

`default_nettype wire

//--- verilog/decode_pkg.sv
`default_nettype none

`include "decode_consts.svh"

package decode_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // one code per operation handed to the alu
    typedef enum logic [4:0] {
        OP_NONE, ADD, SUB, SLT, SLTU, XOR, OR, AND, SLL, SRL, SRA,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        LUI, AUIPC, JAL, JALR
    } alu_op_e;

    typedef enum logic [2:0] {
        FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J, FMT_NONE
    } ins_fmt_e;

    typedef struct packed {
        alu_op_e   op;
        logic      wb_vld;
        reg_addr_t wb_addr;
        word_t     br_st_imm;
    } dec_bundle_t;

    typedef struct packed {
        word_t src1;
        word_t src2;
    } src_pair_t;

endpackage

`default_nettype wire

//--- verilog/decode_consts.svh
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

`define XLEN            32
`define REG_ADDR_W      5

// rv32i base opcodes
`define OP              7'b0110011
`define OP_IMM          7'b0010011
`define LOAD            7'b0000011
`define STORE           7'b0100011
`define BRANCH          7'b1100011
`define LUI             7'b0110111
`define AUIPC           7'b0010111
`define JAL             7'b1101111
`define JALR            7'b1100111

// funct3 codes, branch and load/store tables reuse them
`define FUNCT3_ADD      3'b000
`define FUNCT3_SLL      3'b001
`define FUNCT3_SLT      3'b010
`define FUNCT3_SLTU     3'b011
`define FUNCT3_XOR      3'b100
`define FUNCT3_SR       3'b101
`define FUNCT3_OR       3'b110
`define FUNCT3_AND      3'b111

`define FUNCT7_NORM     7'b0000000
`define FUNCT7_ALT      7'b0100000

`define OP_RNG          6:0
`define RD_RNG          11:7
`define FUNCT3_RNG      14:12
`define RS1_RNG         19:15
`define RS2_RNG         24:20
`define FUNCT7_RNG      31:25

// immediate fields
`define IMM_SIGN_BIT    31
`define I_IMM_RNG       31:20
`define S_IMM_HI_RNG    31:25
`define S_IMM_LO_RNG    11:7
`define B_IMM_11_BIT    7
`define B_IMM_10_5_RNG  30:25
`define B_IMM_4_1_RNG   11:8
`define U_IMM_RNG       31:12
`define J_IMM_19_12_RNG 19:12
`define J_IMM_11_BIT    20
`define J_IMM_10_1_RNG  30:21

`endif
